// File: ffp_add_mix.f
logic/ffp_fmt_pkg.sv
logic/ffp_add_pkg.sv
logic/ffp_align.sv
logic/ffp_result.sv
logic/ffp_add_mix.sv
tests/ffp_add_mix_tb.sv

// File: Bender.yml
package:
  name: ffp_add_mix

sources:
  - logic/ffp_fmt_pkg.sv
  - logic/ffp_add_pkg.sv
  - logic/ffp_align.sv
  - logic/ffp_result.sv
  - logic/ffp_add_mix.sv
  - target: simulation
    files:
      - tests/ffp_add_mix_tb.sv

// File: tests/ffp_add_stimulus.txt
// Columns: case id, mode {align_short, tf32, fp8, int8}, operand a, operand b, expected z
// Operands are {status, sign, exp, man} in 47 bits, z is {status, sign, exp, man} in 48 bits
00 1 000000000064 0000000000c8 00000000012c // int_small
01 1 0000001ffffb 000000000003 1ffffffffffe // int_negative
02 1 0000000fffff 000000000001 0000000fffff // int_sat_pos
03 1 000000100000 0000001fffff 1ffffff00000 // int_sat_neg
04 1 7fffffe00010 000000000010 000000000020 // int_upper_bits
05 4 000a40000000 000a20000000 001860000000 // flt_diff0
06 4 000440000005 000a40000000 001848000000 // flt_diff3_sticky
07 2 003240000000 080bc0000123 00683ffffc00 // flt_diff20_neg
08 4 000ec0000000 000ec0000000 002180000000 // flt_carry
09 2 07fa20000000 0fffa0000000 1003a8000000 // flt_neg_exp
0a c 003c40000000 000470000000 007c40000000 // ovf_short
0b 4 003c40000000 000470000000 007c40000007 // ovf_long
0c 4 000a40000000 170200000000 001840000000 // add_zero_operand
0d 2 410000000000 000a40000000 820080000000 // nan_a
0e 2 000a40000000 490000000000 920380000000 // nan_b
0f 4 210000000000 290000000000 920380000000 // inf_minus_inf
10 4 000a40000000 290000000000 520300000000 // inf_neg
11 4 210000000000 000a40000000 420000000000 // inf_pos
12 4 1f0200000000 170200000000 2e0400000000 // zero_mixed
13 4 1f0200000000 1f0200000000 3e0700000000 // zero_neg
14 4 000a40000000 080bc0000000 2e0400000000 // cancel

// File: tests/ffp_add_mix_tb.sv
`timescale 1ns/1ps

module ffp_add_mix_tb;
    import ffp_fmt_pkg::*;
    import ffp_add_pkg::*;

    localparam int    NUM_VEC    = 21;
    localparam int    VEC_WORDS  = 5;
    localparam int    CLK_PERIOD = 8;
    localparam string STIM_FILE  = "tests/ffp_add_stimulus.txt";

    logic         clk;
    logic         arst_n_i;
    ffp_operand_t a;
    ffp_operand_t b;
    ffp_mode_t    mode;
    logic         valid_in;
    ffp_result_t  z_out;
    logic         valid_out;

    // Five words per vector: id, mode, a, b, z
    logic [47:0]  vec_mem [0:NUM_VEC*VEC_WORDS-1];
    ffp_result_t  exp_queue [$];
    int           id_queue [$];
    int           checked = 0;
    logic         prev_valid_in = 1'b0;

    ffp_add_mix u_dut (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .a_i      (a),
        .b_i      (b),
        .mode_i   (mode),
        .valid_i  (valid_in),
        .z_o      (z_out),
        .valid_o  (valid_out)
    );

    always #(CLK_PERIOD/2) clk = ~clk;

    // ==================================================
    // Reporting
    // ==================================================
    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Verification failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [47:0] expected,
                               input logic [47:0] actual);
        if (expected !== actual) begin
            $display("mismatch %s: expected %h, actual %h", name, expected, actual);
            abort_run("result differs from the expected value");
        end
    endtask

    function automatic string case_name(input int id);
        case (id)
            0:       return "int_small";
            1:       return "int_negative";
            2:       return "int_sat_pos";
            3:       return "int_sat_neg";
            4:       return "int_upper_bits";
            5:       return "flt_diff0";
            6:       return "flt_diff3_sticky";
            7:       return "flt_diff20_neg";
            8:       return "flt_carry";
            9:       return "flt_neg_exp";
            10:      return "ovf_short";
            11:      return "ovf_long";
            12:      return "add_zero_operand";
            13:      return "nan_a";
            14:      return "nan_b";
            15:      return "inf_minus_inf";
            16:      return "inf_neg";
            17:      return "inf_pos";
            18:      return "zero_mixed";
            19:      return "zero_neg";
            20:      return "cancel";
            default: return "unknown_case";
        endcase
    endfunction

    // ==================================================
    // Output checks, sampled on the falling edge
    // ==================================================
    // valid_out must follow valid_in of the previous cycle exactly
    always @(negedge clk) begin : check_outputs
        ffp_result_t expected;
        int          case_id;
        check_value("valid_o timing", prev_valid_in, valid_out);
        prev_valid_in = valid_in;
        if (valid_out) begin
            if (exp_queue.size() == 0) begin
                abort_run("valid_o is high but no operation is in flight");
            end else begin
                expected = exp_queue.pop_front();
                case_id  = id_queue.pop_front();
                check_value(case_name(case_id), expected, z_out);
                checked++;
            end
        end
    end

    // Results stopped arriving
    initial begin : watchdog
        #((NUM_VEC + 20) * CLK_PERIOD);
        abort_run("timeout, results stopped arriving from the DUT");
    end

    // ==================================================
    // Stimulus
    // ==================================================
    initial begin : run_vectors
        int base;
        clk      = 1'b0;
        arst_n_i = 1'b0;
        a        = '0;
        b        = '0;
        mode     = '0;
        valid_in = 1'b0;
        $readmemh(STIM_FILE, vec_mem);
        if ($isunknown(vec_mem[NUM_VEC*VEC_WORDS-1])) begin
            abort_run("stimulus file is missing or holds too few vectors");
        end else begin
            repeat (2) @(posedge clk);
            arst_n_i <= 1'b1;
            // Back to back, one operation per cycle
            for (int i = 0; i < NUM_VEC; i++) begin
                @(posedge clk);
                base = i * VEC_WORDS;
                mode     <= vec_mem[base + 1][3:0];
                a        <= vec_mem[base + 2][46:0];
                b        <= vec_mem[base + 3][46:0];
                valid_in <= 1'b1;
                exp_queue.push_back(vec_mem[base + 4]);
                id_queue.push_back(int'(vec_mem[base]));
            end
            @(posedge clk);
            mode     <= '0;
            a        <= '0;
            b        <= '0;
            valid_in <= 1'b0;
            wait (checked == NUM_VEC);
            // Idle cycles, valid_o has to stay low
            repeat (4) @(posedge clk);
            $display("Verification passed");
            $finish;
        end
    end

endmodule

// File: logic/ffp_add_mix.sv
`timescale 1ns/1ps

module ffp_add_mix (
    input  logic                      clk,
    input  logic                      arst_n_i,
    input  ffp_fmt_pkg::ffp_operand_t a_i,
    input  ffp_fmt_pkg::ffp_operand_t b_i,
    input  ffp_add_pkg::ffp_mode_t    mode_i,
    input  logic                      valid_i,
    output ffp_fmt_pkg::ffp_result_t  z_o,
    output logic                      valid_o
);
    import ffp_add_pkg::*;

    // Registered operation between the two halves
    ffp_stage_t stage;

    // Classify, swap, align, register
    ffp_align u_align (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .a_i           (a_i),
        .b_i           (b_i),
        .mode_i        (mode_i),
        .valid_i       (valid_i),
        .stage_o       (stage),
        .stage_valid_o (valid_o)
    );

    // Add and pack, combinational after the stage
    ffp_result u_result (
        .stage_i (stage),
        .z_o     (z_o)
    );

endmodule

// File: logic/ffp_result.sv
`timescale 1ns/1ps

module ffp_result (
    input  ffp_add_pkg::ffp_stage_t  stage_i,
    output ffp_fmt_pkg::ffp_result_t z_o
);
    import ffp_fmt_pkg::*;
    import ffp_add_pkg::*;

    ffp_add_t             sum;
    logic [INT_OUT_W-1:0] int_sum;
    logic [INT_OUT_W-1:0] int_sat;
    logic                 int_pos_ovf;
    logic                 int_neg_ovf;
    ffp_res_man_t         man;
    ffp_exp_t             exp_inc;
    logic                 is_zero;
    logic                 sign;
    ffp_result_t          z_int;
    ffp_result_t          z_float;

    // Single shared adder for both paths
    assign sum = stage_i.add_a + stage_i.add_b;

    // ==================================================
    // Integer path
    // ==================================================
    assign int_sum = sum[INT_OUT_W-1:0];

    // Upper bits disagree with the sign means the sum left the 21-bit range
    assign int_pos_ovf = ~int_sum[INT_OUT_W-1] & (|int_sum[INT_OUT_W-2:INT_IN_W-1]);
    assign int_neg_ovf = int_sum[INT_OUT_W-1] & ~(&int_sum[INT_OUT_W-2:INT_IN_W-1]);

    always_comb begin
        if (int_pos_ovf) begin
            int_sat = {{(INT_OUT_W-INT_IN_W+1){1'b0}}, {(INT_IN_W-1){1'b1}}};
        end else if (int_neg_ovf) begin
            int_sat = {{(INT_OUT_W-INT_IN_W+1){1'b1}}, {(INT_IN_W-1){1'b0}}};
        end else begin
            int_sat = int_sum;
        end
    end

    // Status stays clear, value fills sign, exponent and mantissa
    assign z_int = {{STATUS_W{1'b0}},
                    {(1+EXP_W+RES_MAN_W-INT_OUT_W){int_sat[INT_OUT_W-1]}},
                    int_sat};

    // ==================================================
    // Float path
    // ==================================================
    assign man     = sum[ADD_W-1:2];
    assign exp_inc = stage_i.large_exp + 1'b1;
    assign is_zero = stage_i.is_zero | (~(|man) & ~(stage_i.is_nan | stage_i.is_inf));
    assign sign    = is_zero ? stage_i.zero_sign : man[RES_MAN_W-1];

    always_comb begin
        z_float.status.nan  = stage_i.is_nan;
        z_float.status.inf  = stage_i.is_inf;
        z_float.status.zero = is_zero;
        if (stage_i.is_nan) begin
            z_float.sign = stage_i.nan_sign;
            z_float.exp  = ffp_exp_t'(EXP_BIAS + 1);
            z_float.man  = {{2{stage_i.nan_sign}}, 1'b1, {(RES_MAN_W-3){1'b0}}};
        end else if (stage_i.is_inf) begin
            z_float.sign = stage_i.inf_sign;
            z_float.exp  = ffp_exp_t'(EXP_BIAS + 1);
            z_float.man  = {{2{stage_i.inf_sign}}, {(RES_MAN_W-2){1'b0}}};
        end else if (is_zero) begin
            z_float.sign = sign;
            z_float.exp  = ffp_exp_t'(-EXP_BIAS);
            z_float.man  = {{2{sign}}, {(RES_MAN_W-2){1'b0}}};
        end else begin
            z_float.sign = sign;
            z_float.exp  = exp_inc;
            z_float.man  = man;
        end
    end

    assign z_o = stage_i.int8 ? z_int : z_float;

    // nan and inf are kept exclusive upstream in the align stage
    assert final ($isunknown(z_o.status) || !(z_o.status.nan && z_o.status.inf));

endmodule

// File: logic/ffp_align.sv
`timescale 1ns/1ps

module ffp_align (
    input  logic                      clk,
    input  logic                      arst_n_i,
    input  ffp_fmt_pkg::ffp_operand_t a_i,
    input  ffp_fmt_pkg::ffp_operand_t b_i,
    input  ffp_add_pkg::ffp_mode_t    mode_i,
    input  logic                      valid_i,
    output ffp_add_pkg::ffp_stage_t   stage_o,
    output logic                      stage_valid_o
);
    import ffp_fmt_pkg::*;
    import ffp_add_pkg::*;

    ffp_operand_t          a_f;
    ffp_operand_t          b_f;
    logic                  a_lt_b;
    ffp_exp_t              large_exp;
    ffp_exp_t              small_exp;
    ffp_man_t              large_man;
    ffp_man_t              small_man;
    ffp_man_t              small_shift;
    ffp_man_t              shifted_out;
    logic signed [EXP_W:0] exp_diff;
    logic signed [EXP_W:0] align_limit;
    logic [SHIFT_W-1:0]    shift;
    logic                  align_ovf;
    logic                  sticky;
    ffp_add_t              large_sig;
    ffp_add_t              small_sig;
    ffp_add_t              int_a;
    ffp_add_t              int_b;
    logic                  inf_nan;
    ffp_stage_t            stage_d;

    // ==================================================
    // Unpack and swap
    // ==================================================
    // Float fields unused in integer mode
    assign a_f = mode_i.int8 ? '0 : a_i;
    assign b_f = mode_i.int8 ? '0 : b_i;

    assign a_lt_b    = $signed(a_f.exp) < $signed(b_f.exp);
    assign large_exp = a_lt_b ? b_f.exp : a_f.exp;
    assign small_exp = a_lt_b ? a_f.exp : b_f.exp;
    assign large_man = a_lt_b ? b_f.man : a_f.man;
    assign small_man = a_lt_b ? a_f.man : b_f.man;

    // One extra bit so the difference cannot wrap
    assign exp_diff = {large_exp[EXP_W-1], large_exp} - {small_exp[EXP_W-1], small_exp};

    // ==================================================
    // Alignment of the smaller mantissa
    // ==================================================
    assign align_limit = mode_i.align_short ? (EXP_W+1)'(ALIGN_LIMIT_SHORT)
                                            : (EXP_W+1)'(ALIGN_LIMIT_LONG);

    assign align_ovf = (exp_diff > align_limit)
                    || (exp_diff > EXP_BIAS + 1)
                    || (exp_diff < -EXP_BIAS);

    assign shift       = exp_diff[SHIFT_W-1:0];
    assign small_shift = ffp_man_t'($signed(small_man) >>> shift);

    // Bits lost off the bottom of the shift
    assign shifted_out = small_man & ~({MAN_W{1'b1}} << shift);
    assign sticky      = |shifted_out;

    assign large_sig = {large_man[MAN_W-1], large_man, 2'b00};
    assign small_sig = align_ovf ? '0 : {small_man[MAN_W-1], small_shift, sticky, 1'b0};

    // Integer channel, low bits sign-extended
    assign int_a = {{(ADD_W-INT_IN_W){a_i[INT_IN_W-1]}}, a_i[INT_IN_W-1:0]};
    assign int_b = {{(ADD_W-INT_IN_W){b_i[INT_IN_W-1]}}, b_i[INT_IN_W-1:0]};

    // inf minus inf
    assign inf_nan = a_f.status.inf & b_f.status.inf & (a_f.sign ^ b_f.sign);

    always_comb begin
        stage_d.add_a     = mode_i.int8 ? int_a : large_sig;
        stage_d.add_b     = mode_i.int8 ? int_b : small_sig;
        stage_d.large_exp = large_exp;
        stage_d.zero_sign = a_f.sign & b_f.sign;
        stage_d.is_nan    = a_f.status.nan | b_f.status.nan | inf_nan;
        stage_d.is_inf    = (a_f.status.inf | b_f.status.inf) & ~stage_d.is_nan;
        stage_d.is_zero   = a_f.status.zero & b_f.status.zero;
        stage_d.inf_sign  = a_f.status.inf ? a_f.sign : b_f.sign;
        if (a_f.status.nan) begin
            stage_d.nan_sign = a_f.sign;
        end else if (b_f.status.nan) begin
            stage_d.nan_sign = b_f.sign;
        end else begin
            stage_d.nan_sign = 1'b1;
        end
        stage_d.int8      = mode_i.int8;
    end

    // ==================================================
    // Stage register
    // ==================================================
    always_ff @(posedge clk) begin
        if (valid_i) begin
            stage_o <= stage_d;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            stage_valid_o <= 1'b0;
        end else begin
            stage_valid_o <= valid_i;
        end
    end

    // Only one format selected per operation
    assert property (@(posedge clk) disable iff (!arst_n_i)
        valid_i |-> $onehot0({mode_i.tf32, mode_i.fp8, mode_i.int8}));

    // Valid has to be known once reset is released
    assert property (@(posedge clk) disable iff (!arst_n_i) !$isunknown(valid_i));

endmodule

// File: logic/ffp_add_pkg.sv
package ffp_add_pkg;

    // ==================================================
    // Datapath widths
    // ==================================================
    // Sign copy, mantissa, sticky and guard
    localparam int ADD_W     = ffp_fmt_pkg::MAN_W + 3;
    localparam int INT_IN_W  = 21;
    localparam int INT_OUT_W = 23;

    // Largest exponent difference that still aligns
    localparam int ALIGN_LIMIT_LONG  = 31;
    localparam int ALIGN_LIMIT_SHORT = 24;
    localparam int SHIFT_W           = 6;

    typedef logic [ADD_W-1:0] ffp_add_t;

    // Operation mode, fp8 and tf32 share the float path
    typedef struct packed {
        logic align_short;
        logic tf32;
        logic fp8;
        logic int8;
    } ffp_mode_t;

    // ==================================================
    // Stage register between align and result
    // ==================================================
    typedef struct packed {
        ffp_add_t              add_a;
        ffp_add_t              add_b;
        ffp_fmt_pkg::ffp_exp_t large_exp;
        logic                  zero_sign;
        logic                  is_nan;
        logic                  is_inf;
        logic                  is_zero;
        logic                  inf_sign;
        logic                  nan_sign;
        logic                  int8;
    } ffp_stage_t;

endpackage

// File: logic/ffp_fmt_pkg.sv
package ffp_fmt_pkg;

    // ==================================================
    // Field widths of the internal float format
    // ==================================================
    localparam int EXP_W     = 10;
    localparam int MAN_W     = 33;
    localparam int RES_MAN_W = 34;
    localparam int STATUS_W  = 3;

    // Zero exponent is -EXP_BIAS, special exponent is EXP_BIAS + 1
    localparam int EXP_BIAS  = 127;

    typedef logic signed [EXP_W-1:0] ffp_exp_t;
    typedef logic [MAN_W-1:0]        ffp_man_t;
    typedef logic [RES_MAN_W-1:0]    ffp_res_man_t;

    // Status flags, nan in the top bit
    typedef struct packed {
        logic nan;
        logic inf;
        logic zero;
    } ffp_status_t;

    // Input operand, 47 bits
    typedef struct packed {
        ffp_status_t status;
        logic        sign;
        ffp_exp_t    exp;
        ffp_man_t    man;
    } ffp_operand_t;

    // Adder result, one extra mantissa bit
    typedef struct packed {
        ffp_status_t  status;
        logic         sign;
        ffp_exp_t     exp;
        ffp_res_man_t man;
    } ffp_result_t;

endpackage
